// ==== src/afi_params.svh ====
/*
 * Sizing and calibration constants for the AFI loopback subsystem
 * Byte masks assume 8-bit lanes, so the data width must be 8 times the mask width
 * The calibration word count must not exceed the loopback array depth
 */
`ifndef AFI_PARAMS_SVH
`define AFI_PARAMS_SVH

// Data path of the x16 interface, one mask bit per byte lane
`define AFI_DATA_WIDTH 16
`define AFI_DM_WIDTH 2

// Row or column address and bank select as seen at the AFI
`define AFI_ADDR_WIDTH 13
`define AFI_BANK_WIDTH 3

// The loopback array holds 16 words, picked by the low address bits
`define PHY_MEM_DEPTH_LOG2 4

// Cycles from the edge of a read command to the edge that samples valid data
`define READ_LATENCY 4

// Calibration writes this many rotated pattern words and reads them back
`define CAL_WORDS 8
`define CAL_PATTERN 16'hA5C3
`define INIT_CYCLES 8

`endif

// ==== src/afi_cmd_pkg.sv ====
/*
 * DDR3 command encoding and the calibration sequencer states
 * Only the commands the loopback PHY can tell apart are listed
 * ZQ calibration and reserved encodings decode as nop
 */
package afi_cmd_pkg;

	// Commands seen on one edge, taken from cs_n, ras_n, cas_n and we_n
	typedef enum logic [2:0] {
		cmd_nop           = 3'd0,
		cmd_activate      = 3'd1,
		cmd_read          = 3'd2,
		cmd_write         = 3'd3,
		cmd_precharge     = 3'd4,
		cmd_refresh       = 3'd5,
		cmd_mode_register = 3'd6
	} afi_cmd_t;

	// Calibration walks these in order and stops in done or failed
	typedef enum logic [2:0] {
		cal_reset_hold = 3'd0,
		cal_init       = 3'd1,
		cal_write      = 3'd2,
		cal_read       = 3'd3,
		cal_wait_data  = 3'd4,
		cal_done       = 3'd5,
		cal_failed     = 3'd6
	} cal_state_t;

	// Standard DDR3 truth table, with chip select high meaning deselect
	function automatic afi_cmd_t decode_cmd(input logic cs_n, input logic ras_n,
		input logic cas_n, input logic we_n);
		if (cs_n)
			return cmd_nop;
		case ({ras_n, cas_n, we_n})
			3'b000: return cmd_mode_register;
			3'b001: return cmd_refresh;
			3'b010: return cmd_precharge;
			3'b011: return cmd_activate;
			3'b100: return cmd_write;
			3'b101: return cmd_read;
			default: return cmd_nop;
		endcase
	endfunction

endpackage

// ==== src/afi_data_pkg.sv ====
/*
 * Data path types of the AFI, sized from the shared parameter header
 * A set mask bit blocks the write of its byte lane
 */
`include "afi_params.svh"

package afi_data_pkg;

	typedef logic [`AFI_DATA_WIDTH-1:0] afi_data_t;
	typedef logic [`AFI_DM_WIDTH-1:0]   afi_dm_t;
	typedef logic [`AFI_ADDR_WIDTH-1:0] afi_addr_t;
	typedef logic [`AFI_BANK_WIDTH-1:0] afi_bank_t;

	// Calibration word idx is the base pattern rotated left by idx bits
	function automatic afi_data_t cal_word(input int idx);
		afi_data_t base;
		int rot;
		base = `CAL_PATTERN;
		rot = idx % `AFI_DATA_WIDTH;
		// A zero rotation shifts the right half out entirely
		return (base << rot) | (base >> (`AFI_DATA_WIDTH - rot));
	endfunction

endpackage

// ==== src/afi_pipe.sv ====
/*
 * Fixed delay line of DEPTH registers for any packed payload type
 * DEPTH must be at least 1, and every stage clears to zero on reset
 */
module afi_pipe #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1
) (
	input  logic     afi_clk,
	input  logic     reset,
	input  payload_t in_data,
	output payload_t out_data
);

	// Stage 0 takes the input, the last stage drives the output
	payload_t stage [DEPTH];

	always_ff @(posedge afi_clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= in_data;
			// Everything moves one stage per clock, there is no stall
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// Data entering on one edge is sampled at the output DEPTH edges later
	assign out_data = stage[DEPTH-1];

endmodule

// ==== src/afi_mux.sv ====
/*
 * Purely combinational owner select between the sequencer and the controller
 * mux_sel high gives the PHY to the sequencer, low gives it to the controller
 * Read data reaches both owners, but the controller never sees a valid during calibration
 */
module afi_mux
	import afi_data_pkg::*;
(
	input  logic      mux_sel,

	// Controller side of the AFI
	input  afi_addr_t afi_address,
	input  afi_bank_t afi_bank,
	input  logic      afi_cs_n,
	input  logic      afi_cke,
	input  logic      afi_ras_n,
	input  logic      afi_cas_n,
	input  logic      afi_we_n,
	input  logic      afi_rst_n,
	input  afi_data_t afi_wdata,
	input  logic      afi_wdata_valid,
	input  afi_dm_t   afi_dm,
	input  logic      afi_rdata_en,
	output afi_data_t afi_rdata,
	output logic      afi_rdata_valid,

	// Sequencer side of the AFI
	input  afi_addr_t seq_mux_address,
	input  afi_bank_t seq_mux_bank,
	input  logic      seq_mux_cs_n,
	input  logic      seq_mux_cke,
	input  logic      seq_mux_ras_n,
	input  logic      seq_mux_cas_n,
	input  logic      seq_mux_we_n,
	input  logic      seq_mux_reset_n,
	input  afi_data_t seq_mux_wdata,
	input  logic      seq_mux_wdata_valid,
	input  afi_dm_t   seq_mux_dm,
	input  logic      seq_mux_rdata_en,
	output afi_data_t mux_seq_rdata,
	output logic      mux_seq_rdata_valid,

	// Toward the PHY
	output afi_addr_t mux_phy_address,
	output afi_bank_t mux_phy_bank,
	output logic      mux_phy_cs_n,
	output logic      mux_phy_cke,
	output logic      mux_phy_ras_n,
	output logic      mux_phy_cas_n,
	output logic      mux_phy_we_n,
	output logic      mux_phy_reset_n,
	output afi_data_t mux_phy_wdata,
	output logic      mux_phy_wdata_valid,
	output afi_dm_t   mux_phy_dm,
	output logic      mux_phy_rdata_en,
	input  afi_data_t phy_mux_rdata,
	input  logic      phy_mux_rdata_valid
);

	// Read return fans out, with the controller valid held low while calibrating
	assign afi_rdata = phy_mux_rdata;
	assign afi_rdata_valid = mux_sel ? 1'b0 : phy_mux_rdata_valid;
	// The sequencer always sees returning data, it compares only its own reads
	assign mux_seq_rdata = phy_mux_rdata;
	assign mux_seq_rdata_valid = phy_mux_rdata_valid;

	// Command, control and write data lanes all switch on the same select
	assign mux_phy_address = mux_sel ? seq_mux_address : afi_address;
	assign mux_phy_bank = mux_sel ? seq_mux_bank : afi_bank;
	assign mux_phy_cs_n = mux_sel ? seq_mux_cs_n : afi_cs_n;
	assign mux_phy_cke = mux_sel ? seq_mux_cke : afi_cke;
	assign mux_phy_ras_n = mux_sel ? seq_mux_ras_n : afi_ras_n;
	assign mux_phy_cas_n = mux_sel ? seq_mux_cas_n : afi_cas_n;
	assign mux_phy_we_n = mux_sel ? seq_mux_we_n : afi_we_n;
	// The controller names its memory reset afi_rst_n
	assign mux_phy_reset_n = mux_sel ? seq_mux_reset_n : afi_rst_n;
	assign mux_phy_wdata = mux_sel ? seq_mux_wdata : afi_wdata;
	assign mux_phy_wdata_valid = mux_sel ? seq_mux_wdata_valid : afi_wdata_valid;
	assign mux_phy_dm = mux_sel ? seq_mux_dm : afi_dm;
	assign mux_phy_rdata_en = mux_sel ? seq_mux_rdata_en : afi_rdata_en;

endmodule

// ==== src/afi_seq.sv ====
/*
 * Calibration sequencer that owns the AFI from reset until the pattern check passes
 * Holds the memory in reset for INIT_CYCLES, sends one mode register command,
 * then writes and reads CAL_WORDS words back to back at addresses 0 upward
 * A pass hands the interface over for good, a failure keeps it until reset
 */
`include "afi_params.svh"

module afi_seq
	import afi_cmd_pkg::*;
	import afi_data_pkg::*;
(
	input  logic      afi_clk,
	input  logic      reset,
	output afi_addr_t seq_mux_address,
	output afi_bank_t seq_mux_bank,
	output logic      seq_mux_cs_n,
	output logic      seq_mux_cke,
	output logic      seq_mux_ras_n,
	output logic      seq_mux_cas_n,
	output logic      seq_mux_we_n,
	output logic      seq_mux_reset_n,
	output afi_data_t seq_mux_wdata,
	output logic      seq_mux_wdata_valid,
	output afi_dm_t   seq_mux_dm,
	output logic      seq_mux_rdata_en,
	input  afi_data_t mux_seq_rdata,
	input  logic      mux_seq_rdata_valid,
	output logic      mux_sel,
	output logic      cal_success,
	output logic      cal_fail
);

	localparam int CNT_W = $clog2(`CAL_WORDS + 1);
	localparam int HOLD_W = $clog2(`INIT_CYCLES + 1);
	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`CAL_WORDS - 1);

	cal_state_t state;
	logic [HOLD_W-1:0] hold_cnt;
	// Counts issued writes, then issued reads
	logic [CNT_W-1:0] cmd_cnt;
	// Counts returned words that matched so far
	logic [CNT_W-1:0] rx_cnt;
	logic rx_check;

	// Data can come back while reads are still going out
	assign rx_check = (state == cal_read) || (state == cal_wait_data);

	always_ff @(posedge afi_clk) begin
		if (reset) begin
			state <= cal_reset_hold;
			hold_cnt <= '0;
			cmd_cnt <= '0;
			rx_cnt <= '0;
		end else begin
			case (state)
				cal_reset_hold: begin
					hold_cnt <= hold_cnt + 1'b1;
					if (hold_cnt == HOLD_W'(`INIT_CYCLES - 1))
						state <= cal_init;
				end
				cal_init: state <= cal_write;
				cal_write: begin
					cmd_cnt <= cmd_cnt + 1'b1;
					if (cmd_cnt == LAST_WORD) begin
						cmd_cnt <= '0;
						state <= cal_read;
					end
				end
				cal_read: begin
					cmd_cnt <= cmd_cnt + 1'b1;
					if (cmd_cnt == LAST_WORD)
						state <= cal_wait_data;
				end
				default: ;
			endcase
			// Returns arrive in issue order, so rx_cnt names the expected word
			if (rx_check && mux_seq_rdata_valid) begin
				if (mux_seq_rdata != cal_word(int'(rx_cnt))) begin
					state <= cal_failed;
				end else begin
					rx_cnt <= rx_cnt + 1'b1;
					if (rx_cnt == LAST_WORD)
						state <= cal_done;
				end
			end
		end
	end

	// Command lines decode straight from the state, idle unless a command is due
	always_comb begin
		seq_mux_address = afi_addr_t'(cmd_cnt);
		seq_mux_bank = '0;
		seq_mux_cs_n = 1'b1;
		seq_mux_cke = 1'b1;
		seq_mux_ras_n = 1'b1;
		seq_mux_cas_n = 1'b1;
		seq_mux_we_n = 1'b1;
		seq_mux_reset_n = 1'b1;
		seq_mux_wdata = cal_word(int'(cmd_cnt));
		seq_mux_wdata_valid = 1'b0;
		// All byte lanes are written during calibration
		seq_mux_dm = '0;
		seq_mux_rdata_en = 1'b0;
		case (state)
			cal_reset_hold: begin
				seq_mux_reset_n = 1'b0;
				seq_mux_cke = 1'b0;
			end
			cal_init: begin
				// Mode register set, all of ras_n, cas_n and we_n low
				seq_mux_cs_n = 1'b0;
				seq_mux_ras_n = 1'b0;
				seq_mux_cas_n = 1'b0;
				seq_mux_we_n = 1'b0;
			end
			cal_write: begin
				seq_mux_cs_n = 1'b0;
				seq_mux_cas_n = 1'b0;
				seq_mux_we_n = 1'b0;
				seq_mux_wdata_valid = 1'b1;
			end
			cal_read: begin
				seq_mux_cs_n = 1'b0;
				seq_mux_cas_n = 1'b0;
				seq_mux_rdata_en = 1'b1;
			end
			default: ;
		endcase
	end

	// Ownership and result flags follow the terminal states
	assign mux_sel = (state != cal_done);
	assign cal_success = (state == cal_done);
	assign cal_fail = (state == cal_failed);

endmodule

// ==== src/afi_loopback_phy.sv ====
/*
 * Behavioral stand-in for the PHY I/O path, not for synthesis into real pads
 * Stores writes in a small array and returns reads after READ_LATENCY edges
 * Bank and upper address bits do not select storage, so addresses alias
 * Commands are ignored while the memory reset is asserted or cke is low
 */
`include "afi_params.svh"

module afi_loopback_phy
	import afi_cmd_pkg::*;
	import afi_data_pkg::*;
(
	input  logic      afi_clk,
	input  logic      reset,
	input  afi_addr_t mux_phy_address,
	input  afi_bank_t mux_phy_bank,
	input  logic      mux_phy_cs_n,
	input  logic      mux_phy_cke,
	input  logic      mux_phy_ras_n,
	input  logic      mux_phy_cas_n,
	input  logic      mux_phy_we_n,
	input  logic      mux_phy_reset_n,
	input  afi_data_t mux_phy_wdata,
	input  logic      mux_phy_wdata_valid,
	input  afi_dm_t   mux_phy_dm,
	input  logic      mux_phy_rdata_en,
	output afi_data_t phy_mux_rdata,
	output logic      phy_mux_rdata_valid
);

	localparam int MEM_WORDS = 1 << `PHY_MEM_DEPTH_LOG2;
	localparam int BYTE_W = `AFI_DATA_WIDTH / `AFI_DM_WIDTH;

	afi_data_t mem [MEM_WORDS];
	afi_cmd_t cmd;
	logic active;
	logic wr_en;
	logic rd_en;
	logic [`PHY_MEM_DEPTH_LOG2-1:0] idx;
	afi_data_t rd_word;

	assign cmd = decode_cmd(mux_phy_cs_n, mux_phy_ras_n, mux_phy_cas_n, mux_phy_we_n);
	assign active = mux_phy_reset_n && mux_phy_cke;
	// A write needs its data in the same cycle, a read needs rdata_en
	assign wr_en = active && (cmd == cmd_write) && mux_phy_wdata_valid;
	assign rd_en = active && (cmd == cmd_read) && mux_phy_rdata_en;
	assign idx = mux_phy_address[`PHY_MEM_DEPTH_LOG2-1:0];

	// Zero when idle keeps the data pipe free of unwritten array contents
	assign rd_word = rd_en ? mem[idx] : '0;

	// Masked lanes keep their old byte
	always_ff @(posedge afi_clk) begin
		if (wr_en) begin
			for (int b = 0; b < `AFI_DM_WIDTH; b++) begin
				if (!mux_phy_dm[b])
					mem[idx][b*BYTE_W +: BYTE_W] <= mux_phy_wdata[b*BYTE_W +: BYTE_W];
			end
		end
	end

	// Valid and data travel side by side, so reads come back in order
	afi_pipe #(
		.payload_t(logic),
		.DEPTH(`READ_LATENCY)
	) u_valid_pipe (
		.afi_clk(afi_clk),
		.reset(reset),
		.in_data(rd_en),
		.out_data(phy_mux_rdata_valid)
	);

	afi_pipe #(
		.payload_t(afi_data_t),
		.DEPTH(`READ_LATENCY)
	) u_data_pipe (
		.afi_clk(afi_clk),
		.reset(reset),
		.in_data(rd_word),
		.out_data(phy_mux_rdata)
	);

endmodule

// ==== src/afi_top.sv ====
/*
 * Sequencer, owner mux and loopback PHY joined at the AFI
 * The controller inputs are ignored until cal_success rises
 * After a failed calibration the controller never gets the interface
 */
module afi_top
	import afi_data_pkg::*;
(
	input  logic      afi_clk,
	input  logic      reset,
	input  afi_addr_t afi_address,
	input  afi_bank_t afi_bank,
	input  logic      afi_cs_n,
	input  logic      afi_cke,
	input  logic      afi_ras_n,
	input  logic      afi_cas_n,
	input  logic      afi_we_n,
	input  logic      afi_rst_n,
	input  afi_data_t afi_wdata,
	input  logic      afi_wdata_valid,
	input  afi_dm_t   afi_dm,
	input  logic      afi_rdata_en,
	output afi_data_t afi_rdata,
	output logic      afi_rdata_valid,
	output logic      cal_success,
	output logic      cal_fail
);

	// Sequencer to mux
	afi_addr_t seq_mux_address;
	afi_bank_t seq_mux_bank;
	logic      seq_mux_cs_n, seq_mux_cke, seq_mux_ras_n, seq_mux_cas_n;
	logic      seq_mux_we_n, seq_mux_reset_n, seq_mux_wdata_valid, seq_mux_rdata_en;
	afi_data_t seq_mux_wdata;
	afi_dm_t   seq_mux_dm;
	afi_data_t mux_seq_rdata;
	logic      mux_seq_rdata_valid;
	logic      mux_sel;

	// Mux to PHY and back
	afi_addr_t mux_phy_address;
	afi_bank_t mux_phy_bank;
	logic      mux_phy_cs_n, mux_phy_cke, mux_phy_ras_n, mux_phy_cas_n;
	logic      mux_phy_we_n, mux_phy_reset_n, mux_phy_wdata_valid, mux_phy_rdata_en;
	afi_data_t mux_phy_wdata;
	afi_dm_t   mux_phy_dm;
	afi_data_t phy_mux_rdata;
	logic      phy_mux_rdata_valid;

	// Port names match the nets above, so the instances connect by name
	afi_seq u_seq (.*);

	afi_mux u_mux (.*);

	afi_loopback_phy u_phy (.*);

endmodule

// ==== verif/afi_asserts.sv ====
/*
 * Concurrent checks on the owner mux, the loopback PHY and the calibration flags
 * Attached at the top level, where the mux, PHY and result nets all meet
 * The read check assumes the memory reset and cke are high at the command edge
 */
`include "afi_params.svh"

module afi_asserts (
	input logic afi_clk,
	input logic reset,
	input logic mux_sel,
	input logic afi_rdata_valid,
	input logic mux_phy_cs_n,
	input logic mux_phy_ras_n,
	input logic mux_phy_cas_n,
	input logic mux_phy_we_n,
	input logic mux_phy_reset_n,
	input logic mux_phy_cke,
	input logic mux_phy_rdata_en,
	input logic phy_mux_rdata_valid,
	input logic cal_success,
	input logic cal_fail
);

	logic rd_cmd;

	// DDR3 read, chip selected with ras_n high, cas_n low and we_n high
	assign rd_cmd = !mux_phy_cs_n && mux_phy_ras_n && !mux_phy_cas_n && mux_phy_we_n &&
		mux_phy_rdata_en && mux_phy_reset_n && mux_phy_cke;

	// The controller must never see calibration read data
	assert property (@(posedge afi_clk) disable iff (reset) mux_sel |-> !afi_rdata_valid)
		else $error("afi_rdata_valid high while the sequencer owns the interface");

	// Every accepted read returns after exactly the read latency
	assert property (@(posedge afi_clk) disable iff (reset)
		rd_cmd |-> ##(`READ_LATENCY) phy_mux_rdata_valid)
		else $error("phy_mux_rdata_valid missing after a read command");

	// Calibration ends in one result only
	assert property (@(posedge afi_clk) disable iff (reset) !(cal_success && cal_fail))
		else $error("cal_success and cal_fail high together");

endmodule

bind afi_top afi_asserts u_asserts (.*);

// ==== verif/afi_tb.sv ====
/*
 * Testbench for the AFI loopback subsystem, driving afi_top as the controller
 * Controller traffic during calibration is kept inside the shortest possible calibration
 * Table rows are issued one per cycle, so reads run back to back where rows allow
 */
`include "afi_params.svh"

module afi_tb
	import afi_data_pkg::*;
;

	localparam int NUM_ROWS = 21;
	localparam int TIMEOUT_CYCLES = `INIT_CYCLES + 2 * `CAL_WORDS + `READ_LATENCY +
		10 * NUM_ROWS + 50;

	logic afi_clk;
	logic reset;
	afi_addr_t afi_address;
	afi_bank_t afi_bank;
	logic afi_cs_n, afi_cke, afi_ras_n, afi_cas_n, afi_we_n, afi_rst_n;
	afi_data_t afi_wdata;
	logic afi_wdata_valid;
	afi_dm_t afi_dm;
	logic afi_rdata_en;
	afi_data_t afi_rdata;
	logic afi_rdata_valid, cal_success, cal_fail;

	// Stimulus table with the expected word of each read row
	string row_name [NUM_ROWS];
	bit row_is_read [NUM_ROWS];
	afi_addr_t row_addr [NUM_ROWS];
	afi_data_t row_data [NUM_ROWS];
	afi_dm_t row_dm [NUM_ROWS];
	afi_data_t row_expect [NUM_ROWS];
	int n_rows = 0;

	// Model of the 16-word loopback array
	afi_data_t ref_mem [1 << `PHY_MEM_DEPTH_LOG2];

	// Reads in flight with the cycle at which their valid must be sampled
	string exp_name_q [$];
	int unsigned exp_cycle_q [$];
	afi_data_t exp_data_q [$];

	int seed = 32'h4088e0df;
	int unsigned cycle = 0;
	int tests_run = 0;
	int failed = 0;
	int cal_valid_seen = 0;
	// Edges during the early calibration traffic where a result flag was already up
	int early_flags = 0;
	string cur_name;
	bit cur_ok;
	int r;

	afi_top u_dut (.*);

	initial begin
		afi_clk = 1'b0;
		forever #2 afi_clk = ~afi_clk;
	end

	// Word i of the pattern is the base rotated left by i bits
	function automatic afi_data_t rotate_pattern(input int i);
		logic [2*`AFI_DATA_WIDTH-1:0] dbl;
		dbl = {`CAL_PATTERN, `CAL_PATTERN};
		return dbl[2*`AFI_DATA_WIDTH-1-(i % `AFI_DATA_WIDTH) -: `AFI_DATA_WIDTH];
	endfunction

	// Appends a row and updates the reference array the way the PHY should
	task automatic add_row(input string name, input bit is_read, input int addr,
		input afi_data_t data, input afi_dm_t dm);
		logic [`PHY_MEM_DEPTH_LOG2-1:0] idx;
		idx = addr[`PHY_MEM_DEPTH_LOG2-1:0];
		row_name[n_rows] = name;
		row_is_read[n_rows] = is_read;
		row_addr[n_rows] = afi_addr_t'(addr);
		row_data[n_rows] = data;
		row_dm[n_rows] = dm;
		row_expect[n_rows] = ref_mem[idx];
		if (!is_read) begin
			for (int b = 0; b < `AFI_DM_WIDTH; b++) begin
				if (!dm[b])
					ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
			end
		end
		n_rows++;
	endtask

	task automatic build_table();
		for (int i = 0; i < `CAL_WORDS; i++)
			ref_mem[i] = rotate_pattern(i);
		for (int i = 0; i < `CAL_WORDS; i++)
			add_row($sformatf("cal_pattern_%0d", i), 1'b1, i, '0, '0);
		add_row("wr_rand_9", 1'b0, 9, afi_data_t'($random(seed)), 2'b00);
		add_row("rd_after_wr_9", 1'b1, 9, '0, '0);
		add_row("wr_rand_10", 1'b0, 10, afi_data_t'($random(seed)), 2'b00);
		add_row("rd_after_wr_10", 1'b1, 10, '0, '0);
		// Upper byte masked, then lower byte masked
		add_row("wr_mask_hi_3", 1'b0, 3, 16'h1234, 2'b10);
		add_row("rd_mask_hi_3", 1'b1, 3, '0, '0);
		add_row("wr_mask_lo_5", 1'b0, 5, afi_data_t'($random(seed)), 2'b01);
		add_row("rd_mask_lo_5", 1'b1, 5, '0, '0);
		add_row("b2b_9", 1'b1, 9, '0, '0);
		add_row("b2b_3", 1'b1, 3, '0, '0);
		add_row("b2b_10", 1'b1, 10, '0, '0);
		add_row("b2b_5", 1'b1, 5, '0, '0);
		add_row("b2b_0", 1'b1, 0, '0, '0);
	endtask

	task automatic drive_idle();
		afi_cs_n <= 1'b1;
		afi_ras_n <= 1'b1;
		afi_cas_n <= 1'b1;
		afi_we_n <= 1'b1;
		afi_wdata_valid <= 1'b0;
		afi_rdata_en <= 1'b0;
	endtask

	task automatic drive_write(input afi_addr_t addr, input afi_data_t data, input afi_dm_t dm);
		afi_address <= addr;
		afi_cs_n <= 1'b0;
		afi_ras_n <= 1'b1;
		afi_cas_n <= 1'b0;
		afi_we_n <= 1'b0;
		afi_wdata <= data;
		afi_wdata_valid <= 1'b1;
		afi_dm <= dm;
		afi_rdata_en <= 1'b0;
	endtask

	task automatic drive_read(input afi_addr_t addr);
		afi_address <= addr;
		afi_cs_n <= 1'b0;
		afi_ras_n <= 1'b1;
		afi_cas_n <= 1'b0;
		afi_we_n <= 1'b1;
		afi_wdata_valid <= 1'b0;
		afi_rdata_en <= 1'b1;
	endtask

	// Cycle count moves on the falling edge so it is stable at every rising edge
	always @(negedge afi_clk) begin
		cycle = cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, calibration or a read never finished", cycle);
			$display("Done: errors found");
			$finish;
		end
	end

	// Read return checker, matching each valid against the oldest read in flight
	always @(posedge afi_clk) begin
		if (!reset && afi_rdata_valid) begin
			if (!cal_success)
				cal_valid_seen++;
			assert (exp_name_q.size() != 0) else begin
				$display("afi_rdata_valid went high at cycle %0d with no read outstanding", cycle);
				tests_run++;
				failed++;
			end
			if (exp_name_q.size() != 0) begin
				cur_name = exp_name_q.pop_front();
				cur_ok = 1'b1;
				assert (cycle == exp_cycle_q[0]) else begin
					$display("** Error %s: valid cycle expected %0d, actual %0d",
						cur_name, exp_cycle_q[0], cycle);
					cur_ok = 1'b0;
				end
				assert (afi_rdata == exp_data_q[0]) else begin
					$display("** Error %s: expected 16'h%04h, actual 16'h%04h",
						cur_name, exp_data_q[0], afi_rdata);
					cur_ok = 1'b0;
				end
				void'(exp_cycle_q.pop_front());
				void'(exp_data_q.pop_front());
				tests_run++;
				if (cur_ok)
					$display("PASS %s", cur_name);
				else
					failed++;
			end
		end
	end

	initial begin
		reset = 1'b1;
		afi_address = '0;
		afi_bank = '0;
		afi_cs_n = 1'b1;
		afi_cke = 1'b1;
		afi_ras_n = 1'b1;
		afi_cas_n = 1'b1;
		afi_we_n = 1'b1;
		afi_rst_n = 1'b1;
		afi_wdata = '0;
		afi_wdata_valid = 1'b0;
		afi_dm = '0;
		afi_rdata_en = 1'b0;
		build_table();
		repeat (2) @(posedge afi_clk);
		reset <= 1'b0;

		// Controller traffic that the mux must keep away from the PHY
		for (int i = 0; i < `INIT_CYCLES + 2 * `CAL_WORDS; i++) begin
			if (i % 2 == 0)
				drive_write(afi_addr_t'(i % `CAL_WORDS), ~rotate_pattern(i), 2'b00);
			else
				drive_read(afi_addr_t'(i % `CAL_WORDS));
			@(posedge afi_clk);
			// Calibration cannot have finished this early, so both flags must be low
			if (cal_success || cal_fail)
				early_flags++;
		end
		drive_idle();
		while (!(cal_success || cal_fail))
			@(posedge afi_clk);

		tests_run++;
		assert (early_flags == 0) else begin
			$display("** Error flags_low_during_cal: expected 0 flagged cycles, actual %0d",
				early_flags);
			failed++;
		end
		if (early_flags == 0)
			$display("PASS flags_low_during_cal");
		tests_run++;
		assert (cal_success && !cal_fail) else begin
			$display("** Error calibration: expected success 1 fail 0, actual success %0b fail %0b",
				cal_success, cal_fail);
			failed++;
		end
		if (cal_success && !cal_fail)
			$display("PASS calibration at cycle %0d", cycle);
		tests_run++;
		assert (cal_valid_seen == 0) else begin
			$display("** Error quiet_during_cal: expected 0 valids, actual %0d", cal_valid_seen);
			failed++;
		end
		if (cal_valid_seen == 0)
			$display("PASS quiet_during_cal");

		if (cal_success) begin
			for (r = 0; r < n_rows; r++) begin
				if (row_is_read[r]) begin
					drive_read(row_addr[r]);
					exp_name_q.push_back(row_name[r]);
					exp_cycle_q.push_back(cycle + 1 + `READ_LATENCY);
					exp_data_q.push_back(row_expect[r]);
				end else begin
					drive_write(row_addr[r], row_data[r], row_dm[r]);
					$display("Issued %s: 16'h%04h to address %0d with dm %b",
						row_name[r], row_data[r], row_addr[r], row_dm[r]);
				end
				@(posedge afi_clk);
			end
			drive_idle();
			while (exp_name_q.size() != 0)
				@(posedge afi_clk);
			// A few more edges to catch a stray valid
			repeat (`READ_LATENCY + 1) @(posedge afi_clk);
		end else begin
			$display("Table skipped because calibration did not pass");
		end

		$display("Summary: %0d tests, %0d passed, %0d failed", tests_run, tests_run - failed,
			failed);
		if (failed == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+src
src/afi_cmd_pkg.sv
src/afi_data_pkg.sv
src/afi_pipe.sv
src/afi_mux.sv
src/afi_seq.sv
src/afi_loopback_phy.sv
src/afi_top.sv
verif/afi_asserts.sv
verif/afi_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the AFI testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module afi_tb -o afi_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/afi_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1
